//--- Makefile
# Verilator build for the control-port byte link testbench.

VERILATOR  ?= verilator
TOP        := cpstr_port_tb
FLIST      := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/cpstr_cmd.sv
/*
 * Command block for escape codes.
 * A ping code raises a reply request that stays up until the escaper
 * acknowledges the pong beat; no further codes are taken meanwhile.
 * Every other code leaves as a registered one-cycle control event.
 */
`timescale 1ns/1ps
`include "cpstr_settings.svh"

module cpstr_cmd
    import cpstr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cpstr_byte_t i_code,
    input  logic        i_valid,
    output logic        o_ready,
    output logic        o_rpl_req,
    input  logic        i_rpl_ack,
    output cpstr_evt_t  o_evt
);

    localparam cpstr_byte_t PING = `CPSTR_CMD_PING;

    logic        code_take;
    logic        is_ping;
    logic        rpl_pend;
    logic        evt_strobe;
    cpstr_byte_t evt_code;

    assign is_ping   = (i_code == PING);
    assign o_ready   = !rpl_pend; // Stall codes behind an open reply.
    assign code_take = i_valid && o_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rpl_pend <= 1'b0;
        end else if (code_take && is_ping) begin
            rpl_pend <= 1'b1;
        end else if (i_rpl_ack) begin
            rpl_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            evt_strobe <= 1'b0;
        end else begin
            evt_strobe <= code_take && !is_ping;
        end
    end

    // Code of the latest event.
    always_ff @(posedge clk) begin
        if (code_take && !is_ping) begin
            evt_code <= i_code;
        end
    end

    assign o_rpl_req    = rpl_pend;
    assign o_evt.strobe = evt_strobe;
    assign o_evt.code   = evt_code;

endmodule

//--- design/cpstr_desc.sv
/*
 * Stream de-escaper.
 * Passes bytes through until an escape byte arrives; that byte is dropped
 * and the byte after it is routed on its own. A second escape byte goes
 * to the payload output, any other byte to the escape output.
 * Purely combinational in the data path, one flag of state.
 */
`timescale 1ns/1ps
`include "cpstr_settings.svh"

module cpstr_desc
    import cpstr_pkg::*;
#(
    parameter cpstr_byte_t ESC_CHAR = `CPSTR_ESC_CHAR
) (
    input  logic        clk,
    input  logic        rst,
    input  cpstr_byte_t i_data,
    input  logic        i_valid,
    output logic        o_ready,
    output cpstr_byte_t o_data,
    output logic        o_valid,
    input  logic        i_ready,
    output cpstr_byte_t o_esc_data,
    output logic        o_esc_valid,
    input  logic        i_esc_ready
);

    localparam logic [1:0] ROUTE_MAIN = 2'd0;
    localparam logic [1:0] ROUTE_ESC  = 2'd1;
    localparam logic [1:0] ROUTE_DROP = 2'd2;

    logic       byte_recv;
    logic       esc_recv; // Previous accepted byte was an escape.
    logic       is_esc;
    logic [1:0] route;

    assign byte_recv = i_valid & o_ready;
    assign is_esc    = (i_data == ESC_CHAR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            esc_recv <= 1'b0;
        end else if (byte_recv) begin
            esc_recv <= !esc_recv && is_esc; // Escape pair ends here.
        end
    end

    always_comb begin
        if (esc_recv) begin
            route = is_esc ? ROUTE_MAIN : ROUTE_ESC;
        end else begin
            route = is_esc ? ROUTE_DROP : ROUTE_MAIN;
        end
    end

    always_comb begin
        o_valid     = 1'b0;
        o_esc_valid = 1'b0;
        o_ready     = 1'b0;
        case (route)
            ROUTE_MAIN: begin
                o_valid = i_valid;
                o_ready = i_ready;
            end
            ROUTE_ESC: begin
                o_esc_valid = i_valid;
                o_ready     = i_esc_ready;
            end
            default: begin
                o_ready = 1'b1; // Lone escape byte is swallowed.
            end
        endcase
    end

    assign o_data     = i_data;
    assign o_esc_data = i_data;

endmodule

//--- design/cpstr_enc.sv
/*
 * Stream escaper.
 * Sends payload bytes out unchanged, except that an escape byte goes out
 * twice. On a reply request it inserts the pair escape byte, pong code
 * between whole payload units and pulses the acknowledge as the pong
 * beat is taken.
 */
`timescale 1ns/1ps
`include "cpstr_settings.svh"

module cpstr_enc
    import cpstr_pkg::*;
#(
    parameter cpstr_byte_t ESC_CHAR = `CPSTR_ESC_CHAR
) (
    input  logic        clk,
    input  logic        rst,
    input  cpstr_byte_t i_data,
    input  logic        i_valid,
    output logic        o_ready,
    input  logic        i_rpl_req,
    output logic        o_rpl_ack,
    output cpstr_byte_t o_data,
    output logic        o_valid,
    input  logic        i_ready
);

    localparam cpstr_byte_t PONG = `CPSTR_RPL_PONG;

    cpstr_enc_state_t state;
    cpstr_enc_state_t state_nxt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ENC_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        o_data    = i_data;
        o_valid   = 1'b0;
        o_ready   = 1'b0;
        o_rpl_ack = 1'b0;
        case (state)
            ENC_IDLE: begin
                if (i_rpl_req) begin
                    // Reply wins over a waiting payload byte.
                    o_data  = ESC_CHAR;
                    o_valid = 1'b1;
                    if (i_ready) begin
                        state_nxt = ENC_RPL;
                    end
                end else if (i_valid) begin
                    o_valid = 1'b1;
                    if (i_data == ESC_CHAR) begin
                        if (i_ready) begin
                            state_nxt = ENC_DUP; // Hold input for the copy.
                        end
                    end else begin
                        o_ready = i_ready; // Plain byte passes straight on.
                    end
                end
            end
            ENC_DUP: begin
                o_data  = ESC_CHAR;
                o_valid = 1'b1;
                o_ready = i_ready; // Input consumed with the second beat.
                if (i_ready) begin
                    state_nxt = ENC_IDLE;
                end
            end
            ENC_RPL: begin
                o_data  = PONG;
                o_valid = 1'b1;
                if (i_ready) begin
                    o_rpl_ack = 1'b1;
                    state_nxt = ENC_IDLE;
                end
            end
            default: begin
                state_nxt = ENC_IDLE;
            end
        endcase
    end

endmodule

//--- design/cpstr_pkg.sv
/*
 * Shared types of the control-port stream link.
 * Modules take these by a wildcard import in their header.
 */
package cpstr_pkg;

    // One byte of any stream in the link.
    typedef logic [7:0] cpstr_byte_t;

    // Escaper FSM states.
    typedef enum logic [1:0] {
        ENC_IDLE = 2'd0, // Next payload byte or reply.
        ENC_DUP  = 2'd1, // Second copy of an escape byte.
        ENC_RPL  = 2'd2  // Pong code of a reply.
    } cpstr_enc_state_t;

    // Control event handed out of the top level.
    typedef struct packed {
        logic        strobe; // High for one cycle per event.
        cpstr_byte_t code;   // Escape code that caused it.
    } cpstr_evt_t;

endpackage

//--- design/cpstr_port.sv
/*
 * Control-port byte link, top level.
 * The input stream is de-escaped; payload is re-escaped on the way out,
 * and escape codes go to the command block. Pings are answered in the
 * output stream, other codes appear on the control event output.
 */
`timescale 1ns/1ps

module cpstr_port
    import cpstr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cpstr_byte_t i_data,
    input  logic        i_valid,
    output logic        o_ready,
    output cpstr_byte_t o_data,
    output logic        o_valid,
    input  logic        i_ready,
    output cpstr_evt_t  o_evt
);

    cpstr_byte_t pld_data;  // De-escaped payload.
    logic        pld_valid;
    logic        pld_ready;
    cpstr_byte_t esc_data;  // Escape codes.
    logic        esc_valid;
    logic        esc_ready;
    logic        rpl_req;
    logic        rpl_ack;

    cpstr_desc i_desc (
        .clk         (clk),
        .rst         (rst),
        .i_data      (i_data),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .o_data      (pld_data),
        .o_valid     (pld_valid),
        .i_ready     (pld_ready),
        .o_esc_data  (esc_data),
        .o_esc_valid (esc_valid),
        .i_esc_ready (esc_ready)
    );

    cpstr_cmd i_cmd (
        .clk       (clk),
        .rst       (rst),
        .i_code    (esc_data),
        .i_valid   (esc_valid),
        .o_ready   (esc_ready),
        .o_rpl_req (rpl_req),
        .i_rpl_ack (rpl_ack),
        .o_evt     (o_evt)
    );

    cpstr_enc i_enc (
        .clk       (clk),
        .rst       (rst),
        .i_data    (pld_data),
        .i_valid   (pld_valid),
        .o_ready   (pld_ready),
        .i_rpl_req (rpl_req),
        .o_rpl_ack (rpl_ack),
        .o_data    (o_data),
        .o_valid   (o_valid),
        .i_ready   (i_ready)
    );

endmodule

//--- design/cpstr_settings.svh
/*
 * Byte codes of the control-port stream link.
 * Include this in any file that needs the escape byte or a command code.
 * The escape byte must differ from the ping code.
 */
`ifndef CPSTR_SETTINGS_SVH
`define CPSTR_SETTINGS_SVH

`define CPSTR_ESC_CHAR 8'd27 // Escape byte in both directions.

`define CPSTR_CMD_PING 8'h50 // Escape code that asks for a reply.

`define CPSTR_RPL_PONG 8'h70 // Code sent after the escape byte in a reply.

`endif

//--- sources.f
+incdir+design
design/cpstr_pkg.sv
design/cpstr_desc.sv
design/cpstr_enc.sv
design/cpstr_cmd.sv
design/cpstr_port.sv
tests/cpstr_port_assert.sv
tests/cpstr_port_tb.sv

//--- tests/cpstr_port_assert.sv
/*
 * Protocol assertions for the link top level.
 * Bound to cpstr_port by the testbench. Checks that a stalled output beat
 * holds, that event strobes never come back to back, and that the output
 * is idle right after reset. The testbench reads the failure count.
 */
`timescale 1ns/1ps

module cpstr_port_assert
    import cpstr_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input cpstr_byte_t o_data,
    input logic        o_valid,
    input logic        i_ready,
    input cpstr_evt_t  o_evt
);

    int fails = 0; // Failed assertion count.

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        o_valid && !i_ready |=> o_valid && $stable(o_data))
    else begin
        $error("output beat changed while stalled");
        fails++;
    end

    a_evt_single: assert property (@(posedge clk) disable iff (rst)
        o_evt.strobe |=> !o_evt.strobe)
    else begin
        $error("event strobe high in two cycles in a row");
        fails++;
    end

    // First edge out of reset.
    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !o_valid)
    else begin
        $error("output valid right after reset");
        fails++;
    end

endmodule

//--- tests/cpstr_port_tb.sv
/*
 * Testbench for the control-port byte link.
 * Builds escaped input messages from an LFSR, drives them with optional
 * gaps and output back-pressure, and compares the output bytes and control
 * events against a reference model of the escaping rules.
 * Prints one line per test and a summary line at the end.
 */
`timescale 1ns/1ps
`include "cpstr_settings.svh"

module cpstr_port_tb
    import cpstr_pkg::*;
;

    localparam cpstr_byte_t ESC     = `CPSTR_ESC_CHAR;
    localparam cpstr_byte_t PING    = `CPSTR_CMD_PING;
    localparam cpstr_byte_t PONG    = `CPSTR_RPL_PONG;
    localparam int          TIMEOUT = 200; // Cycles per wait.

    logic        clk;
    logic        rst;
    cpstr_byte_t i_data;
    logic        i_valid;
    logic        o_ready;
    cpstr_byte_t o_data;
    logic        o_valid;
    logic        i_ready;
    cpstr_evt_t  o_evt;

    logic [31:0] lfsr;
    logic        bp_en;  // Random output back-pressure.
    logic        gap_en; // Random idle cycles between input bytes.
    logic        timed_out;
    int          stalls;
    int          err_cnt;
    int          test_cnt;
    int          test_fail;
    cpstr_byte_t msg_q[$];
    cpstr_byte_t exp_bytes[$];
    cpstr_byte_t exp_evts[$];
    cpstr_byte_t got_bytes[$];
    cpstr_byte_t got_evts[$];

    cpstr_port i_cpstr_port (
        .clk     (clk),
        .rst     (rst),
        .i_data  (i_data),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .o_data  (o_data),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_evt   (o_evt)
    );

    bind cpstr_port cpstr_port_assert i_port_assert (
        .clk     (clk),
        .rst     (rst),
        .o_data  (o_data),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_evt   (o_evt)
    );

    always #5 clk = ~clk;

    // Outputs are settled by the falling edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (o_valid && i_ready) begin
                got_bytes.push_back(o_data);
            end
            if (o_evt.strobe) begin
                got_evts.push_back(o_evt.code);
            end
        end
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Reference model that de-escapes the message and re-escapes the payload.
    function automatic void expected_from_msg();
        logic        after_esc;
        cpstr_byte_t b;
        after_esc = 1'b0;
        exp_bytes.delete();
        exp_evts.delete();
        foreach (msg_q[k]) begin
            b = msg_q[k];
            if (!after_esc) begin
                if (b == ESC) begin
                    after_esc = 1'b1;
                end else begin
                    exp_bytes.push_back(b);
                end
            end else begin
                after_esc = 1'b0;
                if (b == ESC || b == PING) begin
                    exp_bytes.push_back(ESC);
                    exp_bytes.push_back(b == ESC ? ESC : PONG); // Doubled byte or reply.
                end else begin
                    exp_evts.push_back(b);
                end
            end
        end
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Advance to just after the next rising edge and update the output ready.
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        if (bp_en) begin
            rand_bits(2, r);
            i_ready = (r[1:0] != 2'b00);
        end else begin
            i_ready = 1'b1;
        end
    endtask

    // Kind mask bit 0 allows escaped escapes, bit 1 pings, bit 2 event codes.
    task automatic add_unit(input logic [2:0] kinds);
        logic [31:0] sel;
        logic [31:0] r;
        cpstr_byte_t b;
        rand_bits(3, sel);
        rand_bits(8, r);
        b = r[7:0];
        if (sel[2:1] == 2'b10 && kinds[0]) begin
            msg_q.push_back(ESC);
            msg_q.push_back(ESC);
        end else if (sel[2:0] == 3'd6 && kinds[1]) begin
            msg_q.push_back(ESC);
            msg_q.push_back(PING);
        end else if (sel[2:0] == 3'd7 && kinds[2]) begin
            if (b == ESC || b == PING) begin
                b = b ^ 8'h80;
            end
            msg_q.push_back(ESC);
            msg_q.push_back(b);
        end else begin
            msg_q.push_back(b == ESC ? (b ^ 8'h01) : b); // Plain payload.
        end
    endtask

    task automatic send_byte(input cpstr_byte_t b);
        logic [31:0] g;
        logic        taken;
        int          t;
        if (gap_en) begin
            rand_bits(2, g);
            for (t = 0; t < g; t++) begin
                next_cycle();
            end
        end
        i_data  = b;
        i_valid = 1'b1;
        taken   = 1'b0;
        t       = 0;
        while (!taken && t < TIMEOUT) begin
            @(negedge clk);
            taken = o_ready;
            if (!taken) begin
                stalls++;
            end
            next_cycle();
            t++;
        end
        i_valid = 1'b0;
        if (!taken) begin
            report_timeout("input byte was never accepted");
        end
    endtask

    task automatic run_test(input string name, input logic gaps, input logic bp,
                            input logic no_stall);
        int k;
        int t;
        int errs_before;
        if (timed_out) begin
            msg_q.delete();
            return;
        end
        errs_before = err_cnt;
        gap_en      = gaps;
        bp_en       = bp;
        stalls      = 0;
        got_bytes.delete();
        got_evts.delete();
        expected_from_msg();
        foreach (msg_q[n]) begin
            if (!timed_out) begin
                send_byte(msg_q[n]);
            end
        end
        t = 0;
        while (!timed_out
               && (got_bytes.size() < exp_bytes.size() || got_evts.size() < exp_evts.size())
               && t < TIMEOUT) begin
            next_cycle();
            t++;
        end
        if (!timed_out
            && (got_bytes.size() < exp_bytes.size() || got_evts.size() < exp_evts.size())) begin
            report_timeout("output stream did not drain");
        end
        if (!timed_out) begin
            for (k = 0; k < 4; k++) begin
                next_cycle(); // Catch any extra beat.
            end
            if (no_stall) begin
                check_val("o_ready stalls", stalls, 0);
            end
            check_val("output byte count", got_bytes.size(), exp_bytes.size());
            for (k = 0; k < got_bytes.size() && k < exp_bytes.size(); k++) begin
                check_val($sformatf("o_data[%0d]", k), 32'(got_bytes[k]), 32'(exp_bytes[k]));
            end
            check_val("event count", got_evts.size(), exp_evts.size());
            for (k = 0; k < got_evts.size() && k < exp_evts.size(); k++) begin
                check_val($sformatf("o_evt.code[%0d]", k), 32'(got_evts[k]), 32'(exp_evts[k]));
            end
        end
        test_cnt++;
        if (timed_out || err_cnt != errs_before) begin
            test_fail++;
        end
        $display("Test %0d %s: %0d bytes in, %0d out, %0d events, %s", test_cnt, name,
                 msg_q.size(), got_bytes.size(), got_evts.size(),
                 timed_out ? "timeout" : ((err_cnt == errs_before) ? "ok" : "mismatch"));
        msg_q.delete();
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        i_data    = '0;
        i_valid   = 1'b0;
        i_ready   = 1'b1;
        lfsr      = 32'h7d9e1e1d;
        bp_en     = 1'b0;
        gap_en    = 1'b0;
        timed_out = 1'b0;
        stalls    = 0;
        err_cnt   = 0;
        test_cnt  = 0;
        test_fail = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();

        repeat (16) add_unit(3'b000);
        run_test("plain bytes", 1'b0, 1'b0, 1'b1);
        repeat (24) add_unit(3'b001);
        run_test("escaped escapes", 1'b0, 1'b0, 1'b0);
        repeat (48) add_unit(3'b100);
        run_test("event codes", 1'b1, 1'b0, 1'b0);
        repeat (40) add_unit(3'b011);
        run_test("ping replies", 1'b1, 1'b1, 1'b0);
        repeat (400) add_unit(3'b111);
        run_test("random mix", 1'b1, 1'b1, 1'b0);

        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 test_cnt, test_fail, err_cnt, i_cpstr_port.i_port_assert.fails);
        if (err_cnt == 0 && !timed_out && i_cpstr_port.i_port_assert.fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
